// ==== mbist.f ====
verilog/mbist_pkg.sv
verilog/bist_ctrl_if.sv
verilog/test_controller.sv
verilog/address_generator.sv
verilog/pattern_generator.sv
verilog/sram_model.sv
verilog/response_checker.sv
verilog/mbist_top.sv
verification/mbist_sva.sv
verification/mbist_tb.sv

// ==== Bender.yml ====
package:
  name: mbist

sources:
  - verilog/mbist_pkg.sv
  - verilog/bist_ctrl_if.sv
  - verilog/test_controller.sv
  - verilog/address_generator.sv
  - verilog/pattern_generator.sv
  - verilog/sram_model.sv
  - verilog/response_checker.sv
  - verilog/mbist_top.sv
  - target: test
    files:
      - verification/mbist_sva.sv
      - verification/mbist_tb.sv

// ==== verification/mbist_tb.sv ====
// MBIST testbench
module mbist_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADDR_WIDTH     = 4;
  localparam int DATA_WIDTH     = 8;
  localparam int BIT_WIDTH      = $clog2(DATA_WIDTH);
  localparam int NUM_CASES      = 10;
  localparam int TIMEOUT_CYCLES = 1000;

  typedef struct packed {
    logic                  enable;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BIT_WIDTH-1:0]  bit_idx;
    logic                  value;
    logic                  abort_run; // Reset the DUT once the first mismatch shows up
  } fault_case_t;

  logic                  clk;
  logic                  reset;
  logic                  fault_enable;
  logic [ADDR_WIDTH-1:0] fault_addr;
  logic [BIT_WIDTH-1:0]  fault_bit;
  logic                  fault_value;
  logic                  test_done;
  logic                  fail_seen;
  logic [7:0]            error_count;
  logic [ADDR_WIDTH-1:0] first_fail_addr;

  fault_case_t cases [NUM_CASES];
  logic [31:0] lfsr_state;
  logic [3:0]  fail_mask; // Backgrounds that raised error_count in this run
  logic [1:0]  sel_prev;
  logic [7:0]  count_prev;
  int          pass_cases;
  int          fail_cases;
  int          assert_failures;

  mbist_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) DUT (
    .clk             (clk),
    .reset           (reset),
    .fault_enable    (fault_enable),
    .fault_addr      (fault_addr),
    .fault_bit       (fault_bit),
    .fault_value     (fault_value),
    .test_done       (test_done),
    .fail_seen       (fail_seen),
    .error_count     (error_count),
    .first_fail_addr (first_fail_addr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // A count step belongs to the background active in the cycle before it
  always @(negedge clk) begin
    if (reset) begin
      fail_mask  = '0;
      count_prev = '0;
    end else if (error_count != count_prev) begin
      fail_mask[sel_prev] = 1'b1;
      count_prev          = error_count;
    end
    sel_prev = DUT.u_pattern_generator.pattern_sel;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic draw_bits(input int count, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[6:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [3:0] expected_fail_mask(input fault_case_t fc);
    logic       checker_bit;
    logic [3:0] stored; // Bit each background writes into the faulty cell
    checker_bit = fc.bit_idx[0] ^ fc.addr[0]; // Odd bits are set and the word flips at odd addresses
    stored      = {~checker_bit, checker_bit, 1'b1, 1'b0};
    return fc.enable ? (stored ^ {4{fc.value}}) : 4'b0000;
  endfunction

  task automatic compare_value(input string name, input int got, input int exp, inout bit ok);
    if (got != exp) begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      ok = 1'b0;
    end
  endtask

  task automatic wait_for_flag(input bit want_done, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      seen = want_done ? test_done : fail_seen;
      cycles++;
    end
  endtask

  task automatic apply_reset(input fault_case_t fc);
    @(posedge clk);
    reset        <= 1'b1;
    fault_enable <= fc.enable;
    fault_addr   <= fc.addr;
    fault_bit    <= fc.bit_idx;
    fault_value  <= fc.value;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_case(input int idx);
    fault_case_t fc;
    logic [3:0]  exp_mask;
    int          exp_count;
    bit          row_ok;
    bit          seen;
    fc        = cases[idx];
    exp_mask  = expected_fail_mask(fc);
    exp_count = $countones(exp_mask);
    row_ok    = 1'b1;
    apply_reset(fc);
    if (fc.abort_run) begin
      wait_for_flag(1'b0, seen);
      if (!seen) begin
        $display("Case %0d: fail_seen did not rise before the mid-run reset", idx);
        row_ok = 1'b0;
      end
      apply_reset(fc);
      @(negedge clk);
      compare_value("test_done", test_done, 0, row_ok);
      compare_value("fail_seen", fail_seen, 0, row_ok);
      compare_value("error_count", error_count, 0, row_ok);
    end
    wait_for_flag(1'b1, seen);
    if (!seen) begin
      $display("Case %0d: test_done did not rise within %0d cycles", idx, TIMEOUT_CYCLES);
      row_ok = 1'b0;
    end else begin
      @(negedge clk); // Monitor picks up the final count step here
      compare_value("error_count", error_count, exp_count, row_ok);
      compare_value("fail_seen", fail_seen, exp_count != 0, row_ok);
      compare_value("first_fail_addr", first_fail_addr, (exp_count != 0) ? fc.addr : 0, row_ok);
      compare_value("failing backgrounds", fail_mask, exp_mask, row_ok);
    end
    if (row_ok) begin
      pass_cases++;
    end else begin
      fail_cases++;
    end
    $display("Case %0d: fault %0b addr %0d bit %0d value %0b, backgrounds %b: %s",
             idx, fc.enable, fc.addr, fc.bit_idx, fc.value, exp_mask, row_ok ? "ok" : "error");
  endtask

  initial begin
    logic [7:0] bits;
    reset           = 1'b1;
    fault_enable    = 1'b0;
    fault_addr      = '0;
    fault_bit       = '0;
    fault_value     = 1'b0;
    pass_cases      = 0;
    fail_cases      = 0;
    assert_failures = 0;
    lfsr_state      = 32'h296afffb;
    cases[0] = '{1'b0, 4'd0, 3'd0, 1'b0, 1'b0}; // Fault free
    cases[1] = '{1'b1, 4'd5, 3'd3, 1'b0, 1'b0}; // Stuck-at-0
    cases[2] = '{1'b1, 4'd9, 3'd6, 1'b1, 1'b0}; // Stuck-at-1
    cases[3] = '{1'b1, 4'd6, 3'd2, 1'b0, 1'b0}; // Even address, inverse checkerboard fails
    cases[4] = '{1'b1, 4'd7, 3'd2, 1'b0, 1'b0}; // Odd address, checkerboard fails
    cases[5] = '{1'b1, 4'd3, 3'd0, 1'b1, 1'b1};
    for (int i = 6; i < NUM_CASES; i++) begin
      cases[i].enable    = 1'b1;
      cases[i].abort_run = 1'b0;
      draw_bits(ADDR_WIDTH, bits);
      cases[i].addr = bits[ADDR_WIDTH-1:0];
      draw_bits(BIT_WIDTH, bits);
      cases[i].bit_idx = bits[BIT_WIDTH-1:0];
      draw_bits(1, bits);
      cases[i].value = bits[0];
    end
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i);
    end
    assert_failures = DUT.u_test_controller.controller_sva.failures +
                      DUT.u_response_checker.checker_sva.failures;
    $display("Cases run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
             NUM_CASES, pass_cases, fail_cases, assert_failures);
    if (fail_cases == 0 && assert_failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verification/mbist_sva.sv ====
// MBIST sequencing assertions
module mbist_sva (
  input logic clk,
  input logic reset,
  input logic read_only,
  input logic next_pattern,
  input logic enable_checker,
  input logic sticky_flag
);

  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  // Background steps once per strobe
  strobe_single: assert property (@(posedge clk) disable iff (reset)
    next_pattern |=> !next_pattern)
    else begin
      failures++;
      $error("next_pattern stayed high for two cycles");
    end

  check_only_reads: assert property (@(posedge clk) disable iff (reset)
    enable_checker |-> read_only)
    else begin
      failures++;
      $error("enable_checker high while the memory is writing");
    end

  flag_sticky: assert property (@(posedge clk) disable iff (reset)
    sticky_flag |=> sticky_flag)
    else begin
      failures++;
      $error("Status flag dropped without a reset");
    end

endmodule

bind test_controller mbist_sva controller_sva (
  .clk            (clk),
  .reset          (reset),
  .read_only      (ctrl.read_only),
  .next_pattern   (ctrl.next_pattern),
  .enable_checker (ctrl.enable_checker),
  .sticky_flag    (test_done)
);

bind response_checker mbist_sva checker_sva (
  .clk            (clk),
  .reset          (reset),
  .read_only      (ctrl.read_only),
  .next_pattern   (ctrl.next_pattern),
  .enable_checker (ctrl.enable_checker),
  .sticky_flag    (fail_seen)
);

// ==== verilog/mbist_top.sv ====
// MBIST subsystem top level
module mbist_top #(
  parameter int ADDR_WIDTH = 4,
  parameter int DATA_WIDTH = 8
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          fault_enable,
  input  logic [ADDR_WIDTH-1:0]         fault_addr,
  input  logic [$clog2(DATA_WIDTH)-1:0] fault_bit,
  input  logic                          fault_value,
  output logic                          test_done,
  output logic                          fail_seen,
  output mbist_pkg::err_count_t         error_count,
  output logic [ADDR_WIDTH-1:0]         first_fail_addr
);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  addr_t addr;
  logic  addr_done;
  logic  pattern_done;
  data_t expected_data;
  data_t read_data;

  bist_ctrl_if ctrl_if ();

  test_controller u_test_controller (
    .clk          (clk),
    .reset        (reset),
    .addr_done    (addr_done),
    .pattern_done (pattern_done),
    .test_done    (test_done),
    .ctrl         (ctrl_if.ctrl)
  );

  address_generator #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_address_generator (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl_if.gen),
    .addr      (addr),
    .addr_done (addr_done)
  );

  pattern_generator #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_pattern_generator (
    .clk           (clk),
    .reset         (reset),
    .addr_lsb      (addr[0]), // Address parity drives checkerboard inversion
    .ctrl          (ctrl_if.gen),
    .expected_data (expected_data),
    .pattern_done  (pattern_done)
  );

  sram_model #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_sram_model (
    .clk          (clk),
    .addr         (addr),
    .write_data   (expected_data),
    .ctrl         (ctrl_if.mem),
    .fault_enable (fault_enable),
    .fault_addr   (fault_addr),
    .fault_bit    (fault_bit),
    .fault_value  (fault_value),
    .read_data    (read_data)
  );

  response_checker #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_response_checker (
    .clk             (clk),
    .reset           (reset),
    .addr            (addr),
    .expected_data   (expected_data),
    .read_data       (read_data),
    .ctrl            (ctrl_if.mem),
    .error_count     (error_count),
    .first_fail_addr (first_fail_addr),
    .fail_seen       (fail_seen)
  );

endmodule

// ==== verilog/response_checker.sv ====
// MBIST read response checker
module response_checker #(
  parameter int ADDR_WIDTH = 4,
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0] expected_data,
  input  logic [DATA_WIDTH-1:0] read_data,
  bist_ctrl_if.mem              ctrl,
  output mbist_pkg::err_count_t error_count,
  output logic [ADDR_WIDTH-1:0] first_fail_addr,
  output logic                  fail_seen
);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  logic  enable_d;
  addr_t addr_d;
  data_t expected_d;
  logic  mismatch;

  // Match the memory read latency
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      enable_d <= 1'b0;
    end else begin
      enable_d <= ctrl.enable_checker;
    end
  end

  always_ff @(posedge clk) begin
    addr_d     <= addr;
    expected_d <= expected_data;
  end

  assign mismatch = enable_d && (read_data != expected_d);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      error_count     <= '0;
      first_fail_addr <= '0;
      fail_seen       <= 1'b0;
    end else if (mismatch) begin
      if (error_count != '1) begin
        error_count <= error_count + mbist_pkg::err_count_t'(1);
      end
      if (!fail_seen) begin
        first_fail_addr <= addr_d; // Only the first failing word is kept
        fail_seen       <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/sram_model.sv ====
// Single-port SRAM model with stuck-at fault
module sram_model #(
  parameter int ADDR_WIDTH = 4,
  parameter int DATA_WIDTH = 8
) (
  input  logic                          clk,
  input  logic [ADDR_WIDTH-1:0]         addr,
  input  logic [DATA_WIDTH-1:0]         write_data,
  bist_ctrl_if.mem                      ctrl,
  input  logic                          fault_enable,
  input  logic [ADDR_WIDTH-1:0]         fault_addr,
  input  logic [$clog2(DATA_WIDTH)-1:0] fault_bit,
  input  logic                          fault_value,
  output logic [DATA_WIDTH-1:0]         read_data
);

  typedef logic [DATA_WIDTH-1:0] data_t;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  data_t mem [DEPTH];
  data_t cell_word;

  // Faulty cell overrides the stored bit on every read
  always_comb begin
    cell_word = mem[addr];
    if (fault_enable && (addr == fault_addr)) begin
      cell_word[fault_bit] = fault_value;
    end
  end

  always_ff @(posedge clk) begin
    if (!ctrl.read_only) begin
      mem[addr] <= write_data;
    end
    read_data <= cell_word; // One-cycle read latency
  end

endmodule

// ==== verilog/pattern_generator.sv ====
// MBIST data background generator
module pattern_generator #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  addr_lsb,
  bist_ctrl_if.gen              ctrl,
  output logic [DATA_WIDTH-1:0] expected_data,
  output logic                  pattern_done
);

  typedef logic [DATA_WIDTH-1:0] data_t;

  // Even bits clear, odd bits set
  function automatic data_t make_checker();
    data_t word;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      word[i] = i[0];
    end
    return word;
  endfunction

  localparam data_t CHECKER_WORD = make_checker();

  mbist_pkg::pattern_sel_t pattern_sel;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pattern_sel <= mbist_pkg::PAT_ZEROS;
    end else if (ctrl.next_pattern) begin
      pattern_sel <= pattern_sel + mbist_pkg::pattern_sel_t'(1);
    end
  end

  assign pattern_done =
    (pattern_sel == mbist_pkg::pattern_sel_t'(mbist_pkg::NUM_PATTERNS - 1));

  always_comb begin
    case (pattern_sel)
      mbist_pkg::PAT_ZEROS:       expected_data = '0;
      mbist_pkg::PAT_ONES:        expected_data = '1;
      mbist_pkg::PAT_CHECKER:     expected_data = addr_lsb ? ~CHECKER_WORD : CHECKER_WORD;
      mbist_pkg::PAT_INV_CHECKER: expected_data = addr_lsb ? CHECKER_WORD : ~CHECKER_WORD;
      default:                    expected_data = '0;
    endcase
  end

endmodule

// ==== verilog/address_generator.sv ====
// MBIST address counter
module address_generator #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  bist_ctrl_if.gen              ctrl,
  output logic [ADDR_WIDTH-1:0] addr,
  output logic                  addr_done
);

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  localparam addr_t ADDR_MAX = '1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr <= '0;
    end else if (ctrl.addr_gen_reset) begin
      addr <= '0;
    end else if (ctrl.next_addr) begin
      addr <= addr + addr_t'(1); // Wraps to zero after the top address
    end
  end

  // Flags the last address of a sweep
  assign addr_done = (addr == ADDR_MAX);

endmodule

// ==== verilog/test_controller.sv ====
// MBIST sequencing FSM
module test_controller (
  input  logic      clk,
  input  logic      reset,
  input  logic      addr_done,
  input  logic      pattern_done,
  output logic      test_done,
  bist_ctrl_if.ctrl ctrl
);

  mbist_pkg::bist_state_t state;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state             <= mbist_pkg::IDLE;
      ctrl.read_only    <= 1'b0;
      ctrl.next_addr    <= 1'b0;
      ctrl.next_pattern <= 1'b0;
      test_done         <= 1'b0;
    end else begin
      case (state)
        mbist_pkg::IDLE: begin
          state          <= mbist_pkg::WRITING;
          ctrl.read_only <= 1'b0;
          ctrl.next_addr <= 1'b1; // Address sweep starts with the first write
        end

        mbist_pkg::WRITING: begin
          ctrl.next_pattern <= 1'b0;
          ctrl.next_addr    <= 1'b1;
          if (addr_done) begin
            // Last address is written in this cycle
            ctrl.read_only <= 1'b1;
            state          <= mbist_pkg::SWITCHING;
          end
        end

        mbist_pkg::SWITCHING: begin
          ctrl.read_only <= 1'b1;
          state          <= mbist_pkg::READING;
        end

        mbist_pkg::READING: begin
          if (addr_done) begin
            ctrl.next_addr <= 1'b0;
            if (pattern_done) begin
              state <= mbist_pkg::DONE;
            end else begin
              ctrl.next_pattern <= 1'b1; // High for the single NEXT_PATTERN cycle
              state             <= mbist_pkg::NEXT_PATTERN;
            end
          end else begin
            ctrl.next_addr <= 1'b1;
          end
        end

        mbist_pkg::NEXT_PATTERN: begin
          // New background is in place when WRITING begins
          ctrl.next_pattern <= 1'b0;
          ctrl.read_only    <= 1'b0;
          ctrl.next_addr    <= 1'b1;
          state             <= mbist_pkg::WRITING;
        end

        mbist_pkg::DONE: begin
          ctrl.next_pattern <= 1'b0;
          test_done         <= 1'b1; // Sticky until reset
        end

        default: begin
          state <= mbist_pkg::IDLE;
        end
      endcase
    end
  end

  assign ctrl.enable_checker = (state == mbist_pkg::READING);

  // Address is parked at zero before every sweep
  assign ctrl.addr_gen_reset = reset ||
                               (state == mbist_pkg::SWITCHING) ||
                               (state == mbist_pkg::NEXT_PATTERN);

endmodule

// ==== verilog/bist_ctrl_if.sv ====
// MBIST control bundle
interface bist_ctrl_if;

  logic read_only;      // Low means the memory writes this cycle
  logic next_addr;      // Address advances every clock while this level is high
  logic next_pattern;   // One-cycle strobe to step the background
  logic enable_checker;
  logic addr_gen_reset; // Holds the address at zero

  modport ctrl (
    output read_only,
    output next_addr,
    output next_pattern,
    output enable_checker,
    output addr_gen_reset
  );

  // Address and pattern sources
  modport gen (
    input read_only,
    input next_addr,
    input next_pattern,
    input enable_checker,
    input addr_gen_reset
  );

  // Memory and response checker
  modport mem (
    input read_only,
    input next_addr,
    input next_pattern,
    input enable_checker,
    input addr_gen_reset
  );

endinterface

// ==== verilog/mbist_pkg.sv ====
// MBIST shared types
package mbist_pkg;

  // Controller sequencing states
  typedef enum logic [2:0] {
    IDLE         = 3'b000,
    WRITING      = 3'b001,
    SWITCHING    = 3'b010,
    READING      = 3'b011,
    NEXT_PATTERN = 3'b100,
    DONE         = 3'b101
  } bist_state_t;

  // Data background selector
  typedef logic [1:0] pattern_sel_t;

  localparam pattern_sel_t PAT_ZEROS       = 2'd0;
  localparam pattern_sel_t PAT_ONES        = 2'd1;
  localparam pattern_sel_t PAT_CHECKER     = 2'd2; // 0101 from the LSB and inverted at odd addresses
  localparam pattern_sel_t PAT_INV_CHECKER = 2'd3;

  localparam int NUM_PATTERNS = 4;

  // Mismatch counter that saturates at its maximum
  typedef logic [7:0] err_count_t;

endpackage
